//--- vlog.f
source/rv_pkg.sv
source/rv_decode.sv
source/rv_execute.sv
source/rv_hazard_unit.sv
source/rv_pipeline.sv
source/mem_arbiter.sv
source/apb_host_port.sv
source/riscv_soc.sv
tb/riscv_soc_tb.sv

//--- tb/golden_programs.txt
# record letter, then hex fields
# T name | W addr data | R addr expected | E addr (pslverr expected) | G (run until halted)
T apb_mem
R 00001004 00000000
W 000003f0 cafef00d
W 000003f4 0badc0de
R 000003f0 cafef00d
R 000003f4 0badc0de
E 00002000
E 0000100c
T alu_store
# program 1: alu ops, stores, load-use, ecall at 0x60
W 00000000 123450b7
W 00000004 67808093
W 00000008 ffb00113
W 0000000c 002081b3
W 00000010 40208233
W 00000014 0041f2b3
W 00000018 0041e333
W 0000001c 001123b3
W 00000020 0020a433
W 00000024 0f006493
W 00000028 0ff0f593
W 0000002c 20102023
W 00000030 20202223
W 00000034 20302423
W 00000038 20402623
W 0000003c 20502823
W 00000040 20602a23
W 00000044 20702c23
W 00000048 20802e23
W 0000004c 22902023
W 00000050 22b02223
W 00000054 20402603
W 00000058 001606b3
W 0000005c 22d02423
W 00000060 00000073
G
R 00000200 12345678
R 00000204 fffffffb
R 00000208 12345673
R 0000020c 1234567d
R 00000210 12345671
R 00000214 1234567f
R 00000218 00000001
R 0000021c 00000000
R 00000220 000000f0
R 00000224 00000078
T load_use
R 00000228 12345673
T retire
R 00001004 00000001
R 00001008 00000018
T branch_jal
# sentinels the skipped stores would overwrite
W 00000300 5e5e0300
W 00000304 5e5e0304
W 00000308 5e5e0308
W 0000030c 5e5e030c
W 00000310 5e5e0310
W 00000314 5e5e0314
W 00000318 5e5e0318
W 0000031c 5e5e031c
# program 2: beq taken, bne not taken, jal, bne taken
W 00000000 00700093
W 00000004 00700113
W 00000008 00208663
W 0000000c 30102023
W 00000010 30102223
W 00000014 00209463
W 00000018 30202423
W 0000001c 00c002ef
W 00000020 30102623
W 00000024 30102823
W 00000028 30502a23
W 0000002c 00100193
W 00000030 00019463
W 00000034 30302c23
W 00000038 30302e23
W 0000003c 00000073
G
R 00000300 5e5e0300
R 00000304 5e5e0304
R 00000308 00000007
R 0000030c 5e5e030c
R 00000310 5e5e0310
R 00000314 00000020
R 00000318 5e5e0318
R 0000031c 00000001
T rerun_retire
R 00001004 00000001
R 00001008 0000000a

//--- tb/riscv_soc_tb.sv
`default_nettype none

module riscv_soc_tb import rv_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam string golden_path = "tb/golden_programs.txt";
    localparam int cycles_per_run = 2000;
    localparam int cycles_per_apb = 50;
    localparam int reset_cycles = 2;

    logic        clk;
    logic        rst;
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    int    watchdog_cycles;
    int    budget;
    string test_name;

    riscv_soc uut (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [xlen-1:0] expected,
                              input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %s: expected %08h, actual %08h", name, expected, actual));
        end
    endtask

    task automatic check_error(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("[FAIL] %s: expected pslverr %b, actual %b", name, expected,
                                actual));
        end
    endtask

    // setup phase, then access phase until pready
    task automatic apb_transfer(input logic write, input logic [31:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        @(posedge clk);
        #1;
        paddr = addr;
        pwrite = write;
        pwdata = wdata;
        psel = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        // register accesses are already ready here
        while (!pready) begin
            @(posedge clk);
            #1;
        end
        rdata = prdata;
        err = pslverr;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused_rdata;
        logic        unused_err;
        apb_transfer(1'b1, addr, data, unused_rdata, unused_err);
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data,
                            output logic err);
        apb_transfer(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic start_and_wait_halt();
        logic [31:0] status;
        logic        err;
        apb_write(reg_ctrl_addr, 32'h1);
        do begin
            apb_read(reg_status_addr, status, err);
        end while (status[0] !== 1'b1);
    endtask

    task automatic expect_fields(input int code, input int want, input string rec);
        if (code != want) begin
            abort_run($sformatf("malformed %s record in golden file", rec));
        end
    endtask

    // dry pass only sums the cycle budget
    task automatic replay_golden(input bit execute, output int cycles);
        int          fd;
        int          code;
        int          ch;
        string       rec;
        logic [31:0] addr;
        logic [31:0] value;
        logic [31:0] data;
        logic        err;

        cycles = 0;
        fd = $fopen(golden_path, "r");
        if (fd == 0) begin
            abort_run($sformatf("could not open golden file %s", golden_path));
        end
        while ($fscanf(fd, "%s", rec) == 1) begin
            if (rec[0] == "#") begin
                ch = $fgetc(fd);
                while (ch != 10 && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else if (rec == "T") begin
                code = $fscanf(fd, "%s", test_name);
                expect_fields(code, 1, rec);
            end else if (rec == "W") begin
                code = $fscanf(fd, "%h %h", addr, value);
                expect_fields(code, 2, rec);
                cycles += cycles_per_apb;
                if (execute) begin
                    apb_write(addr, value);
                end
            end else if (rec == "R") begin
                code = $fscanf(fd, "%h %h", addr, value);
                expect_fields(code, 2, rec);
                cycles += cycles_per_apb;
                if (execute) begin
                    apb_read(addr, data, err);
                    check_word($sformatf("%s @%08h", test_name, addr), value, data);
                    check_error($sformatf("%s @%08h", test_name, addr), 1'b0, err);
                end
            end else if (rec == "E") begin
                code = $fscanf(fd, "%h", addr);
                expect_fields(code, 1, rec);
                cycles += cycles_per_apb;
                if (execute) begin
                    apb_read(addr, data, err);
                    check_error($sformatf("%s @%08h", test_name, addr), 1'b1, err);
                end
            end else if (rec == "G") begin
                cycles += cycles_per_run;
                if (execute) begin
                    start_and_wait_halt();
                end
            end else begin
                abort_run($sformatf("unknown record %s in golden file", rec));
            end
        end
        $fclose(fd);
    endtask

    initial begin
        rst = 1'b1;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        test_name = "none";
        replay_golden(1'b0, budget);
        watchdog_cycles = budget + reset_cycles + 10;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b0;
        replay_golden(1'b1, budget);
        $display("Test completed successfully");
        $finish;
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: core never halted");
        $display("Test failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

//--- source/riscv_soc.sv
`default_nettype none

module riscv_soc import rv_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);
    mem_req_t        fetch_req;
    mem_req_t        data_req;
    mem_req_t        apb_req;
    logic            fetch_grant;
    logic            data_grant;
    logic            apb_grant;
    logic [xlen-1:0] mem_rdata;
    logic            run;
    logic            halted;
    logic [31:0]     retired;

    rv_pipeline u_core (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .fetch_grant (fetch_grant),
        .data_grant  (data_grant),
        .mem_rdata   (mem_rdata),
        .fetch_req   (fetch_req),
        .data_req    (data_req),
        .halted      (halted),
        .retired     (retired)
    );

    mem_arbiter u_arbiter (
        .clk         (clk),
        .data_req    (data_req),
        .apb_req     (apb_req),
        .fetch_req   (fetch_req),
        .data_grant  (data_grant),
        .apb_grant   (apb_grant),
        .fetch_grant (fetch_grant),
        .rdata       (mem_rdata)
    );

    apb_host_port u_apb (
        .clk       (clk),
        .rst       (rst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .apb_grant (apb_grant),
        .mem_rdata (mem_rdata),
        .halted    (halted),
        .retired   (retired),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .apb_req   (apb_req),
        .run       (run)
    );

endmodule

`default_nettype wire

//--- source/apb_host_port.sv
`default_nettype none

module apb_host_port import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic [31:0]     paddr,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  logic [31:0]     pwdata,
    input  logic            apb_grant,
    input  logic [xlen-1:0] mem_rdata,
    input  logic            halted,
    input  logic [31:0]     retired,
    output logic [31:0]     prdata,
    output logic            pready,
    output logic            pslverr,
    output mem_req_t        apb_req,
    output logic            run
);
    apb_state_e  state;
    logic        in_mem;
    logic        is_reg;
    logic        setup;
    logic        halted_q;
    logic [31:0] reg_rdata;

    assign in_mem = paddr < 32'(mem_words * 4);
    assign setup = (state == apb_idle) && psel && !penable;

    always_comb begin
        is_reg = 1'b1;
        case (paddr)
            reg_ctrl_addr:    reg_rdata = {31'b0, run};
            reg_status_addr:  reg_rdata = {30'b0, run, halted};
            reg_retired_addr: reg_rdata = retired;
            default: begin
                reg_rdata = '0;
                is_reg = 1'b0;
            end
        endcase
    end

    assign apb_req = '{valid: (state == apb_access) && psel && in_mem && !pready,
                       we: pwrite, addr: paddr[mem_aw+1:2], wdata: pwdata};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= apb_idle;
            pready <= 1'b0;
            pslverr <= 1'b0;
            run <= 1'b0;
            halted_q <= 1'b0;
        end else begin
            pready <= 1'b0;
            pslverr <= 1'b0;
            halted_q <= halted;
            // run drops at halt so the next write of 1 is a fresh start
            if (halted && !halted_q) begin
                run <= 1'b0;
            end
            case (state)
                apb_idle: begin
                    if (setup) begin
                        state <= apb_access;
                        if (!in_mem) begin
                            pready <= 1'b1;
                            pslverr <= !is_reg;
                            if (pwrite && paddr == reg_ctrl_addr) begin
                                run <= pwdata[0];
                            end
                        end
                    end
                end
                default: begin
                    if (pready) begin
                        state <= apb_idle;
                    end else if (apb_grant) begin
                        pready <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (setup && !in_mem) begin
            prdata <= reg_rdata;
        end else if (apb_req.valid && apb_grant) begin
            prdata <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

//--- source/mem_arbiter.sv
`default_nettype none

module mem_arbiter import rv_pkg::*; (
    input  logic            clk,
    input  mem_req_t        data_req,
    input  mem_req_t        apb_req,
    input  mem_req_t        fetch_req,
    output logic            data_grant,
    output logic            apb_grant,
    output logic            fetch_grant,
    output logic [xlen-1:0] rdata
);
    logic [xlen-1:0] mem [mem_words];
    grant_e          grant;
    mem_req_t        req;

    // fixed priority: data, then apb, then fetch
    always_comb begin
        if (data_req.valid) begin
            grant = grant_data;
        end else if (apb_req.valid) begin
            grant = grant_apb;
        end else if (fetch_req.valid) begin
            grant = grant_fetch;
        end else begin
            grant = grant_none;
        end
    end

    always_comb begin
        case (grant)
            grant_data:  req = data_req;
            grant_apb:   req = apb_req;
            grant_fetch: req = fetch_req;
            default:     req = '0;
        endcase
    end

    assign data_grant = (grant == grant_data);
    assign apb_grant = (grant == grant_apb);
    assign fetch_grant = (grant == grant_fetch);

    always_ff @(posedge clk) begin
        if (req.valid && req.we) begin
            mem[req.addr] <= req.wdata;
        end
    end

    // same-cycle read of the granted word
    assign rdata = mem[req.addr];

endmodule

`default_nettype wire

//--- source/rv_pipeline.sv
`default_nettype none

module rv_pipeline import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            run,
    input  logic            fetch_grant,
    input  logic            data_grant,
    input  logic [xlen-1:0] mem_rdata,
    output mem_req_t        fetch_req,
    output mem_req_t        data_req,
    output logic            halted,
    output logic [31:0]     retired
);
    logic [xlen-1:0] pc;
    if_id_t          if_id;
    id_ex_t          id_ex;
    id_ex_t          id_ex_next;
    ex_mem_t         ex_mem;
    ex_mem_t         ex_mem_next;
    mem_wb_t         mem_wb;
    logic            valid_e;
    logic            valid_m;
    logic            valid_w;
    logic            run_q;
    logic            start;
    logic            is_ecall;
    logic            ecall_taken;
    logic            ecall_seen;
    logic            stall_f;
    logic            stall_d;
    logic            flush_d;
    logic            flush_e;
    logic            pc_redirect;
    logic [xlen-1:0] redirect_target;
    logic [xlen-1:0] mem_fwd_data;
    logic [xlen-1:0] wb_data;
    fwd_sel_e        fwd_a;
    fwd_sel_e        fwd_b;

    // rising edge of run restarts at pc 0
    assign start = run & ~run_q;
    assign ecall_taken = is_ecall & ~flush_e;

    assign fetch_req = '{valid: run_q & ~ecall_seen & ~ecall_taken, we: 1'b0,
                         addr: pc[mem_aw+1:2], wdata: '0};
    assign data_req = '{valid: ex_mem.mem_read | ex_mem.mem_write, we: ex_mem.mem_write,
                        addr: ex_mem.alu_result[mem_aw+1:2], wdata: ex_mem.write_data};

    always_ff @(posedge clk) begin
        if (rst) begin
            run_q <= 1'b0;
            ecall_seen <= 1'b0;
            halted <= 1'b0;
            retired <= '0;
        end else begin
            run_q <= run;
            if (start) begin
                ecall_seen <= 1'b0;
                halted <= 1'b0;
                retired <= '0;
            end else begin
                if (ecall_taken) begin
                    ecall_seen <= 1'b1;
                end
                // older instructions have drained
                if (ecall_seen && !valid_e && !valid_m && !valid_w) begin
                    halted <= 1'b1;
                end
                if (valid_w) begin
                    retired <= retired + 32'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || start) begin
            pc <= '0;
        end else if (pc_redirect) begin
            pc <= redirect_target;
        end else if (!stall_f) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || start || flush_d) begin
            if_id <= '{valid: 1'b0, pc: '0, instr: nop_word};
        end else if (!stall_d) begin
            if_id <= '{valid: 1'b1, pc: pc, instr: mem_rdata};
        end
    end

    always_ff @(posedge clk) begin
        if (rst || start || flush_e) begin
            id_ex <= '0;
            valid_e <= 1'b0;
        end else begin
            id_ex <= id_ex_next;
            valid_e <= if_id.valid & ~is_ecall;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || start) begin
            ex_mem <= '0;
            mem_wb <= '0;
            valid_m <= 1'b0;
            valid_w <= 1'b0;
        end else begin
            ex_mem <= ex_mem_next;
            valid_m <= valid_e;
            mem_wb <= '{reg_write: ex_mem.reg_write, result_src: ex_mem.result_src,
                        alu_result: ex_mem.alu_result,
                        read_data: data_grant ? mem_rdata : '0,
                        rd: ex_mem.rd, pc_plus4: ex_mem.pc_plus4};
            valid_w <= valid_m;
        end
    end

    assign mem_fwd_data = (ex_mem.result_src == res_pc_plus4) ? ex_mem.pc_plus4
                                                               : ex_mem.alu_result;

    always_comb begin
        case (mem_wb.result_src)
            res_mem:      wb_data = mem_wb.read_data;
            res_pc_plus4: wb_data = mem_wb.pc_plus4;
            default:      wb_data = mem_wb.alu_result;
        endcase
    end

    rv_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .if_id      (if_id),
        .wb_rd      (mem_wb.rd),
        .wb_data    (wb_data),
        .wb_we      (mem_wb.reg_write),
        .id_ex_next (id_ex_next),
        .is_ecall   (is_ecall)
    );

    rv_execute u_execute (
        .id_ex           (id_ex),
        .fwd_a           (fwd_a),
        .fwd_b           (fwd_b),
        .mem_fwd_data    (mem_fwd_data),
        .wb_fwd_data     (wb_data),
        .ex_mem_next     (ex_mem_next),
        .pc_redirect     (pc_redirect),
        .redirect_target (redirect_target)
    );

    rv_hazard_unit u_hazard (
        .rs1_d       (if_id.instr[19:15]),
        .rs2_d       (if_id.instr[24:20]),
        .id_ex       (id_ex),
        .ex_mem      (ex_mem),
        .mem_wb      (mem_wb),
        .pc_redirect (pc_redirect),
        .fetch_grant (fetch_grant),
        .stall_f     (stall_f),
        .stall_d     (stall_d),
        .flush_d     (flush_d),
        .flush_e     (flush_e),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b)
    );

endmodule

`default_nettype wire

//--- source/rv_hazard_unit.sv
`default_nettype none

module rv_hazard_unit import rv_pkg::*; (
    input  logic [4:0] rs1_d,
    input  logic [4:0] rs2_d,
    input  id_ex_t     id_ex,
    input  ex_mem_t    ex_mem,
    input  mem_wb_t    mem_wb,
    input  logic       pc_redirect,
    input  logic       fetch_grant,
    output logic       stall_f,
    output logic       stall_d,
    output logic       flush_d,
    output logic       flush_e,
    output fwd_sel_e   fwd_a,
    output fwd_sel_e   fwd_b
);
    logic load_use;

    // younger result in M wins over W
    function automatic fwd_sel_e fwd_select(input logic [4:0] rs, input ex_mem_t m,
                                            input mem_wb_t w);
        if (m.reg_write && m.rd != 5'd0 && m.rd == rs) begin
            return fwd_mem;
        end
        if (w.reg_write && w.rd != 5'd0 && w.rd == rs) begin
            return fwd_wb;
        end
        return fwd_reg;
    endfunction

    assign fwd_a = fwd_select(id_ex.rs1, ex_mem, mem_wb);
    assign fwd_b = fwd_select(id_ex.rs2, ex_mem, mem_wb);

    assign load_use = id_ex.ctrl.mem_read && id_ex.rd != 5'd0 &&
                      (id_ex.rd == rs1_d || id_ex.rd == rs2_d);

    assign stall_f = load_use | ~fetch_grant;
    assign stall_d = load_use;
    // lost fetch leaves nothing to latch into D
    assign flush_d = pc_redirect | (~fetch_grant & ~load_use);
    assign flush_e = pc_redirect | load_use;

endmodule

`default_nettype wire

//--- source/rv_execute.sv
`default_nettype none

module rv_execute import rv_pkg::*; (
    input  id_ex_t          id_ex,
    input  fwd_sel_e        fwd_a,
    input  fwd_sel_e        fwd_b,
    input  logic [xlen-1:0] mem_fwd_data,
    input  logic [xlen-1:0] wb_fwd_data,
    output ex_mem_t         ex_mem_next,
    output logic            pc_redirect,
    output logic [xlen-1:0] redirect_target
);
    logic [xlen-1:0] src_a;
    logic [xlen-1:0] store_data;
    logic [xlen-1:0] src_b;
    logic [xlen-1:0] alu_result;
    logic            taken;

    function automatic logic [xlen-1:0] fwd_mux(input fwd_sel_e sel,
                                                input logic [xlen-1:0] reg_val,
                                                input logic [xlen-1:0] mem_val,
                                                input logic [xlen-1:0] wb_val);
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign src_a = fwd_mux(fwd_a, id_ex.rd1, mem_fwd_data, wb_fwd_data);
    assign store_data = fwd_mux(fwd_b, id_ex.rd2, mem_fwd_data, wb_fwd_data);
    assign src_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : store_data;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            alu_sub:    alu_result = src_a - src_b;
            alu_and:    alu_result = src_a & src_b;
            alu_or:     alu_result = src_a | src_b;
            alu_slt:    alu_result = {{(xlen-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            alu_pass_b: alu_result = src_b;
            default:    alu_result = src_a + src_b;
        endcase
    end

    // beq/bne compare the forwarded register operands
    assign taken = id_ex.ctrl.branch & ((src_a == store_data) ^ id_ex.ctrl.branch_ne);
    assign pc_redirect = taken | id_ex.ctrl.jump;
    assign redirect_target = id_ex.pc + id_ex.imm;

    assign ex_mem_next = '{reg_write: id_ex.ctrl.reg_write,
                           result_src: id_ex.ctrl.result_src,
                           mem_write: id_ex.ctrl.mem_write,
                           mem_read: id_ex.ctrl.mem_read,
                           alu_result: alu_result,
                           write_data: store_data,
                           rd: id_ex.rd,
                           pc_plus4: id_ex.pc + 32'd4};

endmodule

`default_nettype wire

//--- source/rv_decode.sv
`default_nettype none

module rv_decode import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  if_id_t          if_id,
    input  logic [4:0]      wb_rd,
    input  logic [xlen-1:0] wb_data,
    input  logic            wb_we,
    output id_ex_t          id_ex_next,
    output logic            is_ecall
);
    logic [xlen-1:0] regs [32];
    logic [xlen-1:0] instr;
    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [xlen-1:0] rd1;
    logic [xlen-1:0] rd2;
    ctrl_t           ctrl;
    logic [xlen-1:0] imm;

    function automatic alu_op_e alu_op_for(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  return sub ? alu_sub : alu_add;
            3'b010:  return alu_slt;
            3'b110:  return alu_or;
            3'b111:  return alu_and;
            default: return alu_add;
        endcase
    endfunction

    assign instr = if_id.instr;
    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];

    // x0 is never written, so regs[0] stays zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_rd != 5'd0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // write-first: W result visible in the same cycle
    always_comb begin
        rd1 = regs[rs1];
        rd2 = regs[rs2];
        if (wb_we && wb_rd != 5'd0 && wb_rd == rs1) begin
            rd1 = wb_data;
        end
        if (wb_we && wb_rd != 5'd0 && wb_rd == rs2) begin
            rd2 = wb_data;
        end
    end

    always_comb begin
        ctrl = '0;
        imm = {{20{instr[31]}}, instr[31:20]};
        is_ecall = 1'b0;
        if (if_id.valid) begin
            case (opcode)
                opc_op: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_op = alu_op_for(funct3, instr[30]);
                end
                opc_op_imm: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.alu_op = alu_op_for(funct3, 1'b0);
                end
                opc_lui: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.alu_op = alu_pass_b;
                    imm = {instr[31:12], 12'b0};
                end
                opc_load: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.mem_read = 1'b1;
                    ctrl.result_src = res_mem;
                    ctrl.alu_src_imm = 1'b1;
                end
                opc_store: begin
                    ctrl.mem_write = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                    imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                end
                opc_branch: begin
                    ctrl.branch = 1'b1;
                    ctrl.branch_ne = funct3[0];
                    imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
                end
                opc_jal: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.jump = 1'b1;
                    ctrl.result_src = res_pc_plus4;
                    imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
                end
                opc_system: is_ecall = (instr == ecall_word);
                default: ;
            endcase
        end
    end

    assign id_ex_next = '{ctrl: ctrl, rd1: rd1, rd2: rd2, rs1: rs1, rs2: rs2,
                          rd: instr[11:7], imm: imm, pc: if_id.pc};

endmodule

`default_nettype wire

//--- source/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;
    localparam int mem_words = 1024;
    localparam int mem_aw = 10;

    // apb registers sit above the memory window
    localparam logic [31:0] reg_ctrl_addr = 32'h0000_1000;
    localparam logic [31:0] reg_status_addr = 32'h0000_1004;
    localparam logic [31:0] reg_retired_addr = 32'h0000_1008;

    localparam logic [xlen-1:0] ecall_word = 32'h0000_0073;
    // addi x0, x0, 0
    localparam logic [xlen-1:0] nop_word = 32'h0000_0013;

    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_system = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_slt, alu_pass_b} alu_op_e;
    typedef enum logic [1:0] {res_alu, res_mem, res_pc_plus4} result_src_e;
    typedef enum logic [1:0] {fwd_reg, fwd_mem, fwd_wb} fwd_sel_e;
    typedef enum logic [1:0] {grant_none, grant_data, grant_apb, grant_fetch} grant_e;
    typedef enum logic {apb_idle, apb_access} apb_state_e;

    typedef struct packed {
        logic        reg_write;
        result_src_e result_src;
        logic        mem_write;
        logic        mem_read;
        logic        branch;
        logic        branch_ne;
        logic        jump;
        alu_op_e     alu_op;
        logic        alu_src_imm;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t           ctrl;
        logic [xlen-1:0] rd1;
        logic [xlen-1:0] rd2;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] pc;
    } id_ex_t;

    typedef struct packed {
        logic            reg_write;
        result_src_e     result_src;
        logic            mem_write;
        logic            mem_read;
        logic [xlen-1:0] alu_result;
        logic [xlen-1:0] write_data;
        logic [4:0]      rd;
        logic [xlen-1:0] pc_plus4;
    } ex_mem_t;

    typedef struct packed {
        logic            reg_write;
        result_src_e     result_src;
        logic [xlen-1:0] alu_result;
        logic [xlen-1:0] read_data;
        logic [4:0]      rd;
        logic [xlen-1:0] pc_plus4;
    } mem_wb_t;

    typedef struct packed {
        logic              valid;
        logic              we;
        logic [mem_aw-1:0] addr;
        logic [xlen-1:0]   wdata;
    } mem_req_t;

endpackage

`default_nettype wire
